//--- rv_fetch_unit.f
rv_fetch_pkg.sv
rv_fetch_pc.sv
rv_icache.sv
rv_predecode.sv
rv_fetch_queue.sv
rv_fetch_top.sv
rv_fetch_asserts.sv
rv_fetch_tb.sv

//--- rv_fetch_tb.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch_tb
	import rv_fetch_pkg::*;
;

	localparam int PROG_ROWS = 19;
	localparam int EVENT_ROWS = 7;
	localparam int TIMEOUT_CYCLES = 40 * (PROG_ROWS + EVENT_ROWS) + 16;
	localparam int QUIET_CYCLES = 6;

	localparam int EV_NONE = 0;
	localparam int EV_JUMP = 1;
	localparam int EV_IRQ = 2;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	addr_t i_jump_pc;
	logic i_irq_pending;
	addr_t i_irq_pc;
	logic i_bus_ready;
	word_t i_bus_rdata;
	logic i_decode_busy;

	logic o_irq_dispatched;
	addr_t o_irq_epc;
	logic o_bus_request;
	addr_t o_bus_address;
	logic o_fetch_valid;
	addr_t o_fetch_pc;
	word_t o_fetch_instruction;
	fetch_tag_t o_fetch_tag;
	reg_index_t o_fetch_rs1;
	reg_index_t o_fetch_rs2;
	reg_index_t o_fetch_rs3;
	reg_index_t o_fetch_rd;
	starve_count_t o_starve_count;

	// Program table with address, word, expected indices and control flow flag
	addr_t prog_addr [PROG_ROWS];
	word_t prog_word [PROG_ROWS];
	reg_index_t prog_rs1 [PROG_ROWS];
	reg_index_t prog_rs2 [PROG_ROWS];
	reg_index_t prog_rs3 [PROG_ROWS];
	reg_index_t prog_rd [PROG_ROWS];
	logic prog_stop [PROG_ROWS];
	int prog_count = 0;

	// Event table with the stop pc and the action that follows
	addr_t ev_stop_pc [EVENT_ROWS];
	int ev_kind [EVENT_ROWS];
	addr_t ev_target [EVENT_ROWS];
	logic ev_cached [EVENT_ROWS];
	int ev_count = 0;

	logic [31:0] rand_state = 32'h5360_9203;
	addr_t exp_pc;
	fetch_tag_t exp_tag;
	addr_t stop_pc;
	logic stopped;
	logic expect_no_bus;
	logic bus_serving;
	int bus_wait;
	int bus_transfers;
	int irq_pulses;
	int irq_expected;
	int run_items;
	starve_count_t starve_mark;
	int checks;
	int errors;
	int cycle_count = 0;

	rv_fetch_top #(
		.RESET_VECTOR(32'h100),
		.CACHE_LINES(16),
		.QUEUE_DEPTH(4)
	) i_rv_fetch_top (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata),
		.i_decode_busy(i_decode_busy),
		.o_fetch_valid(o_fetch_valid),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_instruction(o_fetch_instruction),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_rs1(o_fetch_rs1),
		.o_fetch_rs2(o_fetch_rs2),
		.o_fetch_rs3(o_fetch_rs3),
		.o_fetch_rd(o_fetch_rd),
		.o_starve_count(o_starve_count)
	);

	always #2 i_clock = ~i_clock;

	always @(posedge i_clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the event table was not completed",
				cycle_count);
			$display(">>> FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic int find_row(input addr_t addr);
		for (int r = 0; r < PROG_ROWS; r++) begin
			if (prog_addr[r] == addr)
				return r;
		end
		return -1;
	endfunction

	task automatic add_instr(input addr_t addr, input word_t word, input reg_index_t rs1,
		input reg_index_t rs2, input reg_index_t rs3, input reg_index_t rd, input logic stop);
		prog_addr[prog_count] = addr;
		prog_word[prog_count] = word;
		prog_rs1[prog_count] = rs1;
		prog_rs2[prog_count] = rs2;
		prog_rs3[prog_count] = rs3;
		prog_rd[prog_count] = rd;
		prog_stop[prog_count] = stop;
		prog_count++;
	endtask

	task automatic add_event(input addr_t at_pc, input int kind, input addr_t target,
		input logic cached);
		ev_stop_pc[ev_count] = at_pc;
		ev_kind[ev_count] = kind;
		ev_target[ev_count] = target;
		ev_cached[ev_count] = cached;
		ev_count++;
	endtask

	task automatic compare_field(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("Fail %s expected %h actual %h", name, expected, actual);
		end
	endtask

	// Memory model answering after 0 to 3 wait cycles
	task automatic serve_bus();
		int row;
		if (i_bus_ready) begin
			i_bus_ready = 1'b0;
		end else if (o_bus_request) begin
			if (!bus_serving) begin
				bus_serving = 1'b1;
				rand_state = lcg_next(rand_state);
				bus_wait = rand_state[31:16] % 4;
				bus_transfers++;
			end
			if (bus_wait == 0) begin
				row = find_row(o_bus_address);
				if (row < 0) begin
					errors++;
					$display("Bus read at %h lies outside the program", o_bus_address);
					i_bus_rdata = '0;
				end else begin
					i_bus_rdata = prog_word[row];
				end
				i_bus_ready = 1'b1;
				bus_serving = 1'b0;
			end else begin
				bus_wait--;
			end
		end
	endtask

	// Decoder side with random stalls and a check of each popped item
	task automatic serve_decoder();
		int row;
		logic busy_next;
		rand_state = lcg_next(rand_state);
		busy_next = (rand_state[31:16] % 3) == 0;
		if (o_fetch_valid && stopped) begin
			errors++;
			$display("Output at pc %h appeared after control flow and before a jump",
				o_fetch_pc);
		end else if (o_fetch_valid && !busy_next) begin
			row = find_row(exp_pc);
			if (row < 0) begin
				errors++;
				$display("Expected pc %h lies outside the program", exp_pc);
			end else begin
				compare_field($sformatf("pc after %h", stop_pc), exp_pc, o_fetch_pc);
				compare_field($sformatf("word at %h", exp_pc), prog_word[row],
					o_fetch_instruction);
				compare_field($sformatf("tag at %h", exp_pc), exp_tag, o_fetch_tag);
				compare_field($sformatf("rs1 at %h", exp_pc), prog_rs1[row], o_fetch_rs1);
				compare_field($sformatf("rs2 at %h", exp_pc), prog_rs2[row], o_fetch_rs2);
				compare_field($sformatf("rs3 at %h", exp_pc), prog_rs3[row], o_fetch_rs3);
				compare_field($sformatf("rd at %h", exp_pc), prog_rd[row], o_fetch_rd);
				exp_tag = exp_tag + 1'b1;
				run_items++;
				if (prog_stop[row]) begin
					stopped = 1'b1;
					stop_pc = exp_pc;
				end else begin
					exp_pc = exp_pc + 32'd4;
				end
			end
		end
		i_decode_busy = busy_next;
	endtask

	task automatic next_cycle();
		@(negedge i_clock);
		if (o_irq_dispatched) begin
			irq_pulses++;
			compare_field("interrupt epc", stop_pc, o_irq_epc);
		end
		serve_bus();
		serve_decoder();
	endtask

	task automatic apply_event(input int e);
		stopped = 1'b0;
		expect_no_bus = ev_cached[e];
		bus_transfers = 0;
		run_items = 0;
		case (ev_kind[e])
			EV_JUMP: begin
				i_jump = 1'b1;
				i_jump_pc = ev_target[e];
				exp_pc = ev_target[e];
				next_cycle();
				i_jump = 1'b0;
			end
			EV_IRQ: begin
				// Held into the cycle after the dispatch like a source with a late acknowledge
				i_irq_pending = 1'b1;
				i_irq_pc = ev_target[e];
				irq_expected++;
				exp_pc = ev_target[e];
				next_cycle();
				next_cycle();
				i_irq_pending = 1'b0;
			end
			default: stopped = 1'b1;
		endcase
	endtask

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_decode_busy = 1'b0;
		exp_pc = 32'h100;
		exp_tag = '0;
		stop_pc = '0;
		stopped = 1'b0;
		expect_no_bus = 1'b0;
		bus_serving = 1'b0;
		bus_wait = 0;
		bus_transfers = 0;
		irq_pulses = 0;
		irq_expected = 0;
		run_items = 0;
		starve_mark = '0;
		checks = 0;
		errors = 0;

		// R, I, S, U, banked loads and stores, OP_FP, R4, conversions, CSR, B, J
		add_instr(32'h100, {7'h00, 5'd3, 5'd2, 3'd0, 5'd1, OPC_OP}, 6'd2, 6'd3, 6'd0, 6'd1, 0);
		add_instr(32'h104, {12'h012, 5'd6, 3'd0, 5'd5, OPC_OP_IMM}, 6'd6, 6'd0, 6'd0, 6'd5, 0);
		add_instr(32'h108, {7'd0, 5'd7, 5'd8, 3'd2, 5'd8, OPC_STORE}, 6'd8, 6'd7, 6'd0, 6'd0, 0);
		add_instr(32'h10c, {20'h12345, 5'd9, OPC_LUI}, 6'd0, 6'd0, 6'd0, 6'd9, 0);
		add_instr(32'h110, {12'd4, 5'd11, 3'd2, 5'd10, OPC_LOAD_FP},
			6'd11, 6'd0, 6'd0, {1'b1, 5'd10}, 0);
		add_instr(32'h114, {7'd0, 5'd12, 5'd13, 3'd2, 5'd0, OPC_STORE_FP},
			6'd13, {1'b1, 5'd12}, 6'd0, 6'd0, 0);
		add_instr(32'h118, {7'h00, 5'd3, 5'd2, 3'd7, 5'd1, OPC_OP_FP},
			{1'b1, 5'd2}, {1'b1, 5'd3}, 6'd0, {1'b1, 5'd1}, 0);
		add_instr(32'h11c, {5'd7, 2'd0, 5'd6, 5'd5, 3'd7, 5'd4, OPC_MADD},
			{1'b1, 5'd5}, {1'b1, 5'd6}, {1'b1, 5'd7}, {1'b1, 5'd4}, 0);
		// fcvt.w.s keeps rd integer and fmv.w.x keeps rs1 integer
		add_instr(32'h120, {5'b11000, 2'd0, 5'd0, 5'd15, 3'd1, 5'd14, OPC_OP_FP},
			{1'b1, 5'd15}, {1'b1, 5'd0}, 6'd0, 6'd14, 0);
		add_instr(32'h124, {5'b11110, 2'd0, 5'd0, 5'd17, 3'd0, 5'd16, OPC_OP_FP},
			6'd17, {1'b1, 5'd0}, 6'd0, {1'b1, 5'd16}, 0);
		add_instr(32'h128, {12'h300, 5'd19, 3'd1, 5'd18, OPC_SYSTEM}, 6'd19, 6'd0, 6'd0, 6'd18, 0);
		add_instr(32'h12c, {7'd0, 5'd21, 5'd20, 3'd0, 5'd0, OPC_BRANCH},
			6'd20, 6'd21, 6'd0, 6'd0, 1);
		add_instr(32'h130, {20'd0, 5'd1, OPC_JAL}, 6'd0, 6'd0, 6'd0, 6'd1, 1);
		add_instr(32'h134, {20'd1, 5'd22, OPC_AUIPC}, 6'd0, 6'd0, 6'd0, 6'd22, 0);
		add_instr(32'h138, {12'd0, 5'd23, 3'd0, 5'd0, OPC_JALR}, 6'd23, 6'd0, 6'd0, 6'd0, 1);
		add_instr(32'h13c, {F12_ECALL, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 6'd0, 6'd0, 6'd0, 6'd0, 1);
		add_instr(32'h140, {5'b10100, 2'd0, 5'd26, 5'd25, 3'd2, 5'd24, OPC_OP_FP},
			{1'b1, 5'd25}, {1'b1, 5'd26}, 6'd0, 6'd24, 0);
		add_instr(32'h144, {F12_MRET, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 6'd0, 6'd0, 6'd0, 6'd0, 1);
		add_instr(32'h148, {F12_WFI, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 6'd0, 6'd0, 6'd0, 6'd0, 1);

		add_event(32'h12c, EV_JUMP, 32'h130, 0);
		add_event(32'h130, EV_JUMP, 32'h134, 0);
		// Loop back over lines that are now cached
		add_event(32'h138, EV_JUMP, 32'h100, 1);
		add_event(32'h12c, EV_IRQ, 32'h13c, 0);
		add_event(32'h13c, EV_JUMP, 32'h140, 0);
		add_event(32'h144, EV_JUMP, 32'h148, 0);
		add_event(32'h148, EV_NONE, 32'h0, 0);

		repeat (16) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;

		for (int e = 0; e < EVENT_ROWS; e++) begin
			while (!stopped)
				next_cycle();
			compare_field($sformatf("stop %0d pc", e), ev_stop_pc[e], stop_pc);
			if (expect_no_bus) begin
				compare_field("bus transfers on cached pass", 32'd0, bus_transfers);
				// Every hit presents its pc one cycle before the word returns
				compare_field("starve cycles on cached pass", run_items,
					o_starve_count - starve_mark);
			end
			compare_field($sformatf("interrupt count at stop %0d", e), irq_expected,
				irq_pulses);
			starve_mark = o_starve_count;
			repeat (QUIET_CYCLES) next_cycle();
			compare_field($sformatf("starve count while stopped %0d", e), starve_mark,
				o_starve_count);
			apply_event(e);
		end

		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_fetch_asserts.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch_asserts
	import rv_fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)(
	input wire i_clock,
	input wire i_reset,
	input wire i_bus_request,
	input wire i_bus_ready,
	input wire addr_t i_bus_address,
	input wire i_irq_dispatched,
	input wire i_push,
	input wire i_fetch_valid,
	input wire i_decode_busy
);

	int occupancy;
	logic pop;

	assign pop = i_fetch_valid && !i_decode_busy;

	// Shadow of the queue fill level
	always_ff @(posedge i_clock) begin
		if (i_reset)
			occupancy <= 0;
		else
			occupancy <= occupancy + int'(i_push) - int'(pop);
	end

	bus_hold: assert property (@(posedge i_clock) disable iff (i_reset)
		i_bus_request && !i_bus_ready |=> i_bus_request && $stable(i_bus_address))
		else $error("Bus request or address changed before ready");

	irq_single: assert property (@(posedge i_clock) disable iff (i_reset)
		i_irq_dispatched |=> !i_irq_dispatched)
		else $error("Interrupt dispatch pulse lasted two cycles");

	queue_room: assert property (@(posedge i_clock) disable iff (i_reset)
		!(i_push && !pop && occupancy >= QUEUE_DEPTH))
		else $error("Fetch queue written while full");

endmodule

bind rv_fetch_top rv_fetch_asserts #(
	.QUEUE_DEPTH(QUEUE_DEPTH)
) i_rv_fetch_asserts (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_bus_request(o_bus_request),
	.i_bus_ready(i_bus_ready),
	.i_bus_address(o_bus_address),
	.i_irq_dispatched(o_irq_dispatched),
	.i_push(pd_valid),
	.i_fetch_valid(o_fetch_valid),
	.i_decode_busy(i_decode_busy)
);

`default_nettype wire

//--- rv_fetch_top.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch_top
	import rv_fetch_pkg::*;
#(
	parameter addr_t RESET_VECTOR = 32'h0000_0000,
	parameter int CACHE_LINES = 16,
	parameter int QUEUE_DEPTH = 4
)(
	input wire i_clock,
	input wire i_reset,

	input wire i_jump,
	input wire addr_t i_jump_pc,

	input wire i_irq_pending,
	input wire addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,

	output logic o_bus_request,
	input wire i_bus_ready,
	output addr_t o_bus_address,
	input wire word_t i_bus_rdata,

	input wire i_decode_busy,
	output logic o_fetch_valid,
	output addr_t o_fetch_pc,
	output word_t o_fetch_instruction,
	output fetch_tag_t o_fetch_tag,
	output reg_index_t o_fetch_rs1,
	output reg_index_t o_fetch_rs2,
	output reg_index_t o_fetch_rs3,
	output reg_index_t o_fetch_rd,

	output starve_count_t o_starve_count
);

	addr_t pc;
	logic fetch_enable;
	logic redirect;

	logic cache_valid;
	word_t cache_word;
	addr_t cache_pc;

	logic flow_change;
	logic pd_valid;
	addr_t pd_pc;
	word_t pd_word;
	fetch_tag_t pd_tag;
	reg_index_t pd_rs1;
	reg_index_t pd_rs2;
	reg_index_t pd_rs3;
	reg_index_t pd_rd;

	logic queue_ready;

	rv_fetch_pc #(
		.RESET_VECTOR(RESET_VECTOR)
	) i_rv_fetch_pc (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.o_pc(pc),
		.o_fetch_enable(fetch_enable),
		.o_redirect(redirect),
		.i_cache_valid(cache_valid),
		.i_flow_change(flow_change),
		.i_queue_ready(queue_ready),
		.o_starve_count(o_starve_count)
	);

	rv_icache #(
		.CACHE_LINES(CACHE_LINES)
	) i_rv_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_pc(pc),
		.i_fetch_enable(fetch_enable),
		.i_redirect(redirect),
		.o_valid(cache_valid),
		.o_word(cache_word),
		.o_word_pc(cache_pc),
		.o_bus_request(o_bus_request),
		.i_bus_ready(i_bus_ready),
		.o_bus_address(o_bus_address),
		.i_bus_rdata(i_bus_rdata)
	);

	rv_predecode i_rv_predecode (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(cache_valid),
		.i_word(cache_word),
		.i_pc(cache_pc),
		.o_flow_change(flow_change),
		.o_valid(pd_valid),
		.o_pc(pd_pc),
		.o_word(pd_word),
		.o_tag(pd_tag),
		.o_rs1(pd_rs1),
		.o_rs2(pd_rs2),
		.o_rs3(pd_rs3),
		.o_rd(pd_rd)
	);

	rv_fetch_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_rv_fetch_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_valid(pd_valid),
		.i_pc(pd_pc),
		.i_word(pd_word),
		.i_tag(pd_tag),
		.i_rs1(pd_rs1),
		.i_rs2(pd_rs2),
		.i_rs3(pd_rs3),
		.i_rd(pd_rd),
		.o_queue_ready(queue_ready),
		.i_decode_busy(i_decode_busy),
		.o_fetch_valid(o_fetch_valid),
		.o_fetch_pc(o_fetch_pc),
		.o_fetch_instruction(o_fetch_instruction),
		.o_fetch_tag(o_fetch_tag),
		.o_fetch_rs1(o_fetch_rs1),
		.o_fetch_rs2(o_fetch_rs2),
		.o_fetch_rs3(o_fetch_rs3),
		.o_fetch_rd(o_fetch_rd)
	);

endmodule

`default_nettype wire

//--- rv_fetch_queue.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch_queue
	import rv_fetch_pkg::*;
#(
	parameter int QUEUE_DEPTH = 4
)(
	input wire i_clock,
	input wire i_reset,

	// From predecode
	input wire i_valid,
	input wire addr_t i_pc,
	input wire word_t i_word,
	input wire fetch_tag_t i_tag,
	input wire reg_index_t i_rs1,
	input wire reg_index_t i_rs2,
	input wire reg_index_t i_rs3,
	input wire reg_index_t i_rd,

	output logic o_queue_ready,

	// Towards the decoder
	input wire i_decode_busy,
	output logic o_fetch_valid,
	output addr_t o_fetch_pc,
	output word_t o_fetch_instruction,
	output fetch_tag_t o_fetch_tag,
	output reg_index_t o_fetch_rs1,
	output reg_index_t o_fetch_rs2,
	output reg_index_t o_fetch_rs3,
	output reg_index_t o_fetch_rd
);

	localparam int PTR_BITS = $clog2(QUEUE_DEPTH);
	localparam int COUNT_BITS = $clog2(QUEUE_DEPTH + 1);

	addr_t pc_mem [QUEUE_DEPTH];
	word_t word_mem [QUEUE_DEPTH];
	fetch_tag_t tag_mem [QUEUE_DEPTH];
	reg_index_t rs1_mem [QUEUE_DEPTH];
	reg_index_t rs2_mem [QUEUE_DEPTH];
	reg_index_t rs3_mem [QUEUE_DEPTH];
	reg_index_t rd_mem [QUEUE_DEPTH];

	logic [PTR_BITS-1:0] head;
	logic [PTR_BITS-1:0] tail;
	logic [COUNT_BITS-1:0] count;
	logic pop;

	function automatic logic [PTR_BITS-1:0] advance(input logic [PTR_BITS-1:0] ptr);
		if (ptr == PTR_BITS'(QUEUE_DEPTH - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	// Room for a new lookup plus the word still in predecode
	assign o_queue_ready = (int'(count) + 3) <= QUEUE_DEPTH;

	assign o_fetch_valid = (count != '0);
	assign pop = o_fetch_valid && !i_decode_busy;

	assign o_fetch_pc = pc_mem[head];
	assign o_fetch_instruction = word_mem[head];
	assign o_fetch_tag = tag_mem[head];
	assign o_fetch_rs1 = rs1_mem[head];
	assign o_fetch_rs2 = rs2_mem[head];
	assign o_fetch_rs3 = rs3_mem[head];
	assign o_fetch_rd = rd_mem[head];

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			if (i_valid)
				tail <= advance(tail);
			if (pop)
				head <= advance(head);
			case ({i_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			pc_mem[tail] <= i_pc;
			word_mem[tail] <= i_word;
			tag_mem[tail] <= i_tag;
			rs1_mem[tail] <= i_rs1;
			rs2_mem[tail] <= i_rs2;
			rs3_mem[tail] <= i_rs3;
			rd_mem[tail] <= i_rd;
		end
	end

endmodule

`default_nettype wire

//--- rv_predecode.sv
`default_nettype none
`timescale 1ns/10ps

module rv_predecode
	import rv_fetch_pkg::*;
(
	input wire i_clock,
	input wire i_reset,

	input wire i_valid,
	input wire word_t i_word,
	input wire addr_t i_pc,

	output logic o_flow_change,

	output logic o_valid,
	output addr_t o_pc,
	output word_t o_word,
	output fetch_tag_t o_tag,
	output reg_index_t o_rs1,
	output reg_index_t o_rs2,
	output reg_index_t o_rs3,
	output reg_index_t o_rd
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [4:0] funct5;
	logic [11:0] funct12;

	logic is_r, is_r4, is_i, is_s, is_b, is_u, is_j, is_csr;
	logic is_fp_op, is_priv;
	logic rs1_bank, rs2_bank, rd_bank;
	fetch_tag_t next_tag;

	assign opcode = i_word[6:0];
	assign funct3 = i_word[14:12];
	assign funct5 = i_word[31:27];
	assign funct12 = i_word[31:20];

	always_comb begin
		is_r = 1'b0;
		is_r4 = 1'b0;
		is_i = 1'b0;
		is_s = 1'b0;
		is_b = 1'b0;
		is_u = 1'b0;
		is_j = 1'b0;
		is_csr = 1'b0;
		case (opcode)
			OPC_OP, OPC_OP_FP: is_r = 1'b1;
			OPC_MADD, OPC_MSUB, OPC_NMSUB, OPC_NMADD: is_r4 = 1'b1;
			OPC_LOAD, OPC_LOAD_FP, OPC_OP_IMM, OPC_JALR: is_i = 1'b1;
			OPC_STORE, OPC_STORE_FP: is_s = 1'b1;
			OPC_BRANCH: is_b = 1'b1;
			OPC_LUI, OPC_AUIPC: is_u = 1'b1;
			OPC_JAL: is_j = 1'b1;
			OPC_SYSTEM: is_csr = 1'b1;
			default: ;
		endcase
	end

	assign is_fp_op = (opcode == OPC_OP_FP);

	// Float bank selection, moves and conversions keep one side integer
	assign rd_bank = is_r4 || (opcode == OPC_LOAD_FP) ||
		(is_fp_op && !(funct5 inside {F5_FCVT_W_S, F5_FMV_X_W, F5_FCMP}));
	assign rs1_bank = is_r4 || (is_fp_op && !(funct5 inside {F5_FCVT_S_W, F5_FMV_W_X}));
	assign rs2_bank = is_r4 || is_fp_op || (opcode == OPC_STORE_FP);

	assign is_priv = is_csr && (funct3 == F3_PRIV) &&
		(funct12 inside {F12_ECALL, F12_MRET, F12_WFI});
	assign o_flow_change = i_valid &&
		((opcode inside {OPC_JAL, OPC_JALR, OPC_BRANCH}) || is_priv);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			next_tag <= '0;
		end else begin
			o_valid <= i_valid;
			if (i_valid)
				next_tag <= next_tag + 1'b1;
		end
	end

	// Absent fields read as register zero of the integer bank
	always_ff @(posedge i_clock) begin
		if (i_valid) begin
			o_pc <= i_pc;
			o_word <= i_word;
			o_tag <= next_tag;
			o_rs1 <= (is_r || is_r4 || is_i || is_s || is_b || is_csr) ?
				{rs1_bank, i_word[19:15]} : '0;
			o_rs2 <= (is_r || is_r4 || is_s || is_b) ? {rs2_bank, i_word[24:20]} : '0;
			o_rs3 <= is_r4 ? {1'b1, i_word[31:27]} : '0;
			o_rd <= (is_r || is_r4 || is_i || is_u || is_j || is_csr) ?
				{rd_bank, i_word[11:7]} : '0;
		end
	end

endmodule

`default_nettype wire

//--- rv_icache.sv
`default_nettype none
`timescale 1ns/10ps

module rv_icache
	import rv_fetch_pkg::*;
#(
	parameter int CACHE_LINES = 16
)(
	input wire i_clock,
	input wire i_reset,

	// Lookup from the pc stage
	input wire addr_t i_pc,
	input wire i_fetch_enable,
	input wire i_redirect,

	// Returned word
	output logic o_valid,
	output word_t o_word,
	output addr_t o_word_pc,

	// Memory bus
	output logic o_bus_request,
	input wire i_bus_ready,
	output addr_t o_bus_address,
	input wire word_t i_bus_rdata
);

	localparam int INDEX_BITS = $clog2(CACHE_LINES);
	localparam int TAG_BITS = 30 - INDEX_BITS;

	typedef enum logic {
		CACHE_LOOKUP,
		CACHE_MISS
	} cache_state_t;

	cache_state_t state;

	logic [CACHE_LINES-1:0] line_valid;
	logic [TAG_BITS-1:0] tag_array [CACHE_LINES];
	word_t data_array [CACHE_LINES];

	logic [INDEX_BITS-1:0] pc_index;
	logic [TAG_BITS-1:0] pc_tag;
	logic [INDEX_BITS-1:0] fill_index;
	logic [TAG_BITS-1:0] fill_tag;

	addr_t miss_pc;
	logic hit;
	logic lookup;
	logic fill;
	logic out_valid;
	logic stale;

	assign pc_index = i_pc[2 +: INDEX_BITS];
	assign pc_tag = i_pc[31 -: TAG_BITS];
	assign fill_index = miss_pc[2 +: INDEX_BITS];
	assign fill_tag = miss_pc[31 -: TAG_BITS];

	assign hit = line_valid[pc_index] && (tag_array[pc_index] == pc_tag);

	// No new lookup while a word is on the output, its pc is about to move
	assign lookup = (state == CACHE_LOOKUP) && i_fetch_enable && !out_valid;
	assign fill = (state == CACHE_MISS) && i_bus_ready;

	assign o_bus_request = (state == CACHE_MISS);
	assign o_bus_address = miss_pc;

	// Drop the word when the pc stage has just moved elsewhere
	assign o_valid = out_valid && !i_redirect;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= CACHE_LOOKUP;
			line_valid <= '0;
			out_valid <= 1'b0;
			stale <= 1'b0;
		end else begin
			out_valid <= 1'b0;

			case (state)
				CACHE_LOOKUP: begin
					if (lookup) begin
						if (hit) begin
							out_valid <= 1'b1;
						end else begin
							state <= CACHE_MISS;
							stale <= 1'b0;
						end
					end
				end

				CACHE_MISS: begin
					if (i_redirect)
						stale <= 1'b1;
					if (fill) begin
						line_valid[fill_index] <= 1'b1;
						out_valid <= !(stale || i_redirect);
						state <= CACHE_LOOKUP;
					end
				end

				default:
					state <= CACHE_LOOKUP;
			endcase
		end
	end

	// Arrays and returned word
	always_ff @(posedge i_clock) begin
		if (lookup) begin
			o_word <= data_array[pc_index];
			o_word_pc <= i_pc;
			miss_pc <= i_pc;
		end

		// Fill the line and hand the same word on
		if (fill) begin
			tag_array[fill_index] <= fill_tag;
			data_array[fill_index] <= i_bus_rdata;
			o_word <= i_bus_rdata;
			o_word_pc <= miss_pc;
		end
	end

endmodule

`default_nettype wire

//--- rv_fetch_pc.sv
`default_nettype none
`timescale 1ns/10ps

module rv_fetch_pc
	import rv_fetch_pkg::*;
#(
	parameter addr_t RESET_VECTOR = 32'h0000_0000
)(
	input wire i_clock,
	input wire i_reset,

	// Jump from the decoder
	input wire i_jump,
	input wire addr_t i_jump_pc,

	// Interrupt
	input wire i_irq_pending,
	input wire addr_t i_irq_pc,
	output logic o_irq_dispatched,
	output addr_t o_irq_epc,

	// Towards the cache
	output addr_t o_pc,
	output logic o_fetch_enable,
	output logic o_redirect,

	input wire i_cache_valid,
	input wire i_flow_change,
	input wire i_queue_ready,
	output starve_count_t o_starve_count
);

	pc_state_t state;
	addr_t pc;
	logic irq_take;

	// A returning word is accepted first, the interrupt follows a cycle later
	assign irq_take = i_irq_pending && !o_irq_dispatched && !i_cache_valid;

	assign o_pc = pc;
	assign o_fetch_enable = (state == FETCH) && i_queue_ready;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FETCH;
			pc <= RESET_VECTOR;
			o_redirect <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_starve_count <= '0;
		end else begin
			o_redirect <= 1'b0;
			o_irq_dispatched <= 1'b0;

			if (irq_take) begin
				pc <= i_irq_pc;
				state <= FETCH;
				o_redirect <= 1'b1;
				o_irq_dispatched <= 1'b1;
			end else begin
				case (state)
					FETCH: begin
						if (i_cache_valid) begin
							// Hold pc on control flow until the target is known
							if (i_flow_change)
								state <= WAIT_JUMP;
							else
								pc <= pc + 32'd4;
						end else if (i_queue_ready) begin
							o_starve_count <= o_starve_count + 1'b1;
						end
					end

					WAIT_JUMP: begin
						if (i_jump) begin
							pc <= i_jump_pc;
							state <= FETCH;
							o_redirect <= 1'b1;
						end
					end

					default:
						state <= FETCH;
				endcase
			end
		end
	end

	// Interrupted pc, kept until the next dispatch
	always_ff @(posedge i_clock) begin
		if (irq_take && !i_reset)
			o_irq_epc <= pc;
	end

endmodule

`default_nettype wire

//--- rv_fetch_pkg.sv
`default_nettype none

package rv_fetch_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;

	// Bank bit on top, register number below
	typedef logic [5:0] reg_index_t;

	typedef logic [7:0] fetch_tag_t;
	typedef logic [31:0] starve_count_t;

	typedef enum logic {
		FETCH,
		WAIT_JUMP
	} pc_state_t;

	// Major opcodes
	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_LOAD_FP  = 7'b0000111;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_STORE_FP = 7'b0100111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;
	localparam logic [6:0] OPC_OP_FP    = 7'b1010011;
	localparam logic [6:0] OPC_MADD     = 7'b1000011;
	localparam logic [6:0] OPC_MSUB     = 7'b1000111;
	localparam logic [6:0] OPC_NMSUB    = 7'b1001011;
	localparam logic [6:0] OPC_NMADD    = 7'b1001111;

	// Privileged instructions under SYSTEM
	localparam logic [2:0]  F3_PRIV   = 3'b000;
	localparam logic [11:0] F12_ECALL = 12'h000;
	localparam logic [11:0] F12_MRET  = 12'h302;
	localparam logic [11:0] F12_WFI   = 12'h105;

	// OP_FP funct5 values that touch the integer bank
	localparam logic [4:0] F5_FCVT_W_S = 5'b11000;
	localparam logic [4:0] F5_FMV_X_W  = 5'b11100;
	localparam logic [4:0] F5_FCMP     = 5'b10100;
	localparam logic [4:0] F5_FCVT_S_W = 5'b11010;
	localparam logic [4:0] F5_FMV_W_X  = 5'b11110;

endpackage

`default_nettype wire
